//--- logic/mmu_pkg.sv
// Widths, vector types and packets shared by the data translation path; modules import it whole
package mmu_pkg;

  localparam int VADDR_W    = 39;
  localparam int PAGE_OFF_W = 12;
  localparam int VTAG_W     = VADDR_W - PAGE_OFF_W;
  localparam int PTAG_W     = 28;
  localparam int PADDR_W    = PTAG_W + PAGE_OFF_W;
  // Domain id sits in the top bits of the physical tag
  localparam int DID_W      = 2;

  typedef logic [VADDR_W-1:0]    vaddr_t;
  typedef logic [VTAG_W-1:0]     vtag_t;
  typedef logic [PTAG_W-1:0]     ptag_t;
  typedef logic [PAGE_OFF_W-1:0] page_off_t;
  typedef logic [PADDR_W-1:0]    paddr_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_e;

  typedef struct packed {
    vaddr_t vaddr;
    logic   store_not_load;
  } mmu_cmd_s;

  // Leaf PTE fields kept in the TLB
  typedef struct packed {
    ptag_t ptag;
    logic  u;
    logic  w;
    logic  d;
  } tlb_entry_s;

  typedef struct packed {
    logic   miss;
    logic   load_page_fault;
    logic   store_page_fault;
    logic   access_fault;
    paddr_t paddr;
  } mmu_resp_s;

  // Registered TLB result, travels with its command
  typedef struct packed {
    logic       hit;
    tlb_entry_s entry;
    mmu_cmd_s   cmd;
  } tlb_lookup_s;

endpackage

//--- logic/dtlb.sv
// Fully associative data TLB; filled from outside, flushed by sfence, lookup registered one cycle
`timescale 1ns/1ns

module dtlb
  import mmu_pkg::*;
#(
  parameter int TLB_ELS = 8
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        flush_i,
  input  logic        translation_en_i,
  input  logic        cmd_v_i,
  input  mmu_cmd_s    cmd_i,
  input  logic        fill_v_i,
  input  vtag_t       fill_vtag_i,
  input  tlb_entry_s  fill_entry_i,
  output logic        lookup_v_o,
  output tlb_lookup_s lookup_o
);

  localparam int IDX_W = $clog2(TLB_ELS);

  vtag_t              tag_r   [TLB_ELS];
  tlb_entry_s         entry_r [TLB_ELS];
  logic [TLB_ELS-1:0] valid_r;
  logic [IDX_W-1:0]   victim_r;
  logic [TLB_ELS-1:0] match;
  logic [IDX_W-1:0]   match_idx;
  logic [IDX_W-1:0]   fill_idx;
  vtag_t              cmd_vtag;
  vtag_t              cam_vtag;
  tlb_entry_s         bare_entry;
  logic               lookup_v_r;
  tlb_lookup_s        lookup_r;

  assign cmd_vtag = cmd_i.vaddr[VADDR_W-1:PAGE_OFF_W];

  // One compare bank, shared by fills and lookups
  assign cam_vtag = fill_v_i ? fill_vtag_i : cmd_vtag;

  always_comb begin
    match_idx = '0;
    for (int i = 0; i < TLB_ELS; i++) begin
      match[i] = valid_r[i] && (tag_r[i] == cam_vtag);
      if (match[i]) begin
        match_idx = IDX_W'(i);
      end
    end
  end

  // A refill of a resident page overwrites it in place
  assign fill_idx = (|match) ? match_idx : victim_r;

  // Translation off: identity map, never misses
  assign bare_entry = '{ptag: PTAG_W'(cmd_vtag), u: 1'b0, w: 1'b1, d: 1'b1};

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx]   <= fill_vtag_i;
      entry_r[fill_idx] <= fill_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
    end
  end

  // Round-robin victim
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_r <= '0;
    end else if (fill_v_i && !(|match)) begin
      victim_r <= (victim_r == IDX_W'(TLB_ELS - 1)) ? '0 : victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_v_r <= 1'b0;
    end else begin
      lookup_v_r <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      lookup_r.cmd <= cmd_i;
      if (translation_en_i) begin
        lookup_r.hit   <= |match;
        lookup_r.entry <= (|match) ? entry_r[match_idx] : '0;
      end else begin
        lookup_r.hit   <= 1'b1;
        lookup_r.entry <= bare_entry;
      end
    end
  end

  assign lookup_v_o = lookup_v_r;
  assign lookup_o   = lookup_r;

  a_no_fill_with_cmd : assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_v_i && cmd_v_i))
    else $error("dtlb fill collided with a command");

  a_single_match : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(match))
    else $error("dtlb holds duplicate tags");

endmodule

//--- logic/pte_check.sv
// Combinational permission and domain checks on the registered TLB lookup, builds the response
`timescale 1ns/1ns

module pte_check
  import mmu_pkg::*;
(
  input  tlb_lookup_s lookup_i,
  input  logic        translation_en_i,
  input  priv_e       priv_i,
  input  logic        sum_i,
  output mmu_resp_s   check_o
);

  tlb_entry_s entry;
  page_off_t  page_off;
  logic       store;
  logic       miss;
  logic       checked;
  logic       priv_fault;
  logic       write_fault;

  assign entry    = lookup_i.entry;
  assign page_off = lookup_i.cmd.vaddr[PAGE_OFF_W-1:0];
  assign store    = lookup_i.cmd.store_not_load;

  // Bare mode forces a hit, so these only bite when translating
  assign miss    = translation_en_i & ~lookup_i.hit;
  assign checked = translation_en_i & lookup_i.hit;

  always_comb begin
    case (priv_i)
      PRIV_U:  priv_fault = ~entry.u;
      PRIV_S:  priv_fault = ~sum_i & entry.u;
      PRIV_M:  priv_fault = 1'b0;
      default: priv_fault = 1'b0;
    endcase
  end

  assign write_fault = store & (~entry.w | ~entry.d);

  assign check_o.miss             = miss;
  assign check_o.load_page_fault  = checked & ~store & priv_fault;
  assign check_o.store_page_fault = checked & store & (priv_fault | write_fault);
  // Only domain zero is reachable
  assign check_o.access_fault     = ~miss & (entry.ptag[PTAG_W-1 -: DID_W] != '0);
  assign check_o.paddr            = {entry.ptag, page_off};

endmodule

//--- logic/resp_stage.sv
// Final pipeline stage: applies the late poison kill, registers the response, tracks miss vaddr
`timescale 1ns/1ns

module resp_stage
  import mmu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        lookup_v_i,
  input  tlb_lookup_s lookup_i,
  input  mmu_resp_s   check_i,
  input  logic        poison_i,
  output logic        resp_v_o,
  output mmu_resp_s   resp_o,
  output vaddr_t      miss_vaddr_o
);

  logic      accept;
  logic      resp_v_r;
  mmu_resp_s resp_r;
  vaddr_t    miss_vaddr_r;

  // Poison lands while the command sits in its lookup cycle
  assign accept = lookup_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      resp_r <= check_i;
    end
  end

  // Held for the walker side until the next miss
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_vaddr_r <= '0;
    end else if (accept && check_i.miss) begin
      miss_vaddr_r <= lookup_i.cmd.vaddr;
    end
  end

  assign resp_v_o     = resp_v_r;
  assign resp_o       = resp_r;
  assign miss_vaddr_o = miss_vaddr_r;

  a_one_outcome : assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> $onehot0({resp_o.miss, resp_o.load_page_fault, resp_o.store_page_fault}))
    else $error("response reports more than one of miss and page faults");

endmodule

//--- logic/dmmu_top.sv
// Data MMU top level: TLB lookup, permission check and response register, two-cycle latency
`timescale 1ns/1ns

module dmmu_top
  import mmu_pkg::*;
#(
  parameter int TLB_ELS = 8
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_v_i,
  input  mmu_cmd_s   cmd_i,
  input  logic       poison_i,
  input  logic       fill_v_i,
  input  vtag_t      fill_vtag_i,
  input  tlb_entry_s fill_entry_i,
  input  logic       flush_i,
  input  logic       translation_en_i,
  input  priv_e      priv_i,
  input  logic       sum_i,
  output logic       resp_v_o,
  output mmu_resp_s  resp_o,
  output vaddr_t     miss_vaddr_o
);

  logic        lookup_v;
  tlb_lookup_s lookup;
  mmu_resp_s   check;

  dtlb #(
    .TLB_ELS(TLB_ELS)
  ) u_dtlb (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .translation_en_i(translation_en_i),
    .cmd_v_i         (cmd_v_i),
    .cmd_i           (cmd_i),
    .fill_v_i        (fill_v_i),
    .fill_vtag_i     (fill_vtag_i),
    .fill_entry_i    (fill_entry_i),
    .lookup_v_o      (lookup_v),
    .lookup_o        (lookup)
  );

  pte_check u_pte_check (
    .lookup_i        (lookup),
    .translation_en_i(translation_en_i),
    .priv_i          (priv_i),
    .sum_i           (sum_i),
    .check_o         (check)
  );

  resp_stage u_resp_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lookup_v_i  (lookup_v),
    .lookup_i    (lookup),
    .check_i     (check),
    .poison_i    (poison_i),
    .resp_v_o    (resp_v_o),
    .resp_o      (resp_o),
    .miss_vaddr_o(miss_vaddr_o)
  );

endmodule

//--- sim/tb_dmmu.sv
// Directed testbench for dmmu_top; compares each response two cycles after its command
`timescale 1ns/1ns

module tb_dmmu
  import mmu_pkg::*;
();

  // Commands issued over all tests
  localparam int CMD_COUNT = 44;
  localparam int WATCHDOG_CYCLES = CMD_COUNT * 10 + 200;

  typedef struct packed {
    logic [31:0] due;
    logic        v;
    mmu_resp_s   r;
  } exp_s;

  logic       clk_i;
  logic       reset_i;
  logic       cmd_v_i;
  mmu_cmd_s   cmd_i;
  logic       poison_i;
  logic       fill_v_i;
  vtag_t      fill_vtag_i;
  tlb_entry_s fill_entry_i;
  logic       flush_i;
  logic       translation_en_i;
  priv_e      priv_i;
  logic       sum_i;
  logic       resp_v_o;
  mmu_resp_s  resp_o;
  vaddr_t     miss_vaddr_o;

  exp_s        exp_q[$];
  int          cycle_cnt;
  logic [31:0] lcg_state;
  string       test_name;

  dmmu_top DUT (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic vaddr_t rand_vaddr();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[30:24], lo};
  endfunction

  function automatic ptag_t rand_ptag(logic [DID_W-1:0] did);
    logic [31:0] x;
    x = lcg_next();
    return {did, x[31 -: PTAG_W-DID_W]};
  endfunction

  // Expected response from the translation rules
  function automatic mmu_resp_s model_resp(mmu_cmd_s cmd, logic xlate, priv_e priv,
                                           logic sum, logic present, tlb_entry_s ent);
    mmu_resp_s r;
    ptag_t     ptag;
    logic      priv_fault;
    logic      write_fault;
    r = '0;
    if (!xlate) begin
      r.paddr = PADDR_W'(cmd.vaddr);
    end else if (!present) begin
      r.miss = 1'b1;
    end else begin
      priv_fault  = (priv == PRIV_S && !sum && ent.u) || (priv == PRIV_U && !ent.u);
      write_fault = cmd.store_not_load && (!ent.w || !ent.d);
      r.load_page_fault  = !cmd.store_not_load && priv_fault;
      r.store_page_fault = cmd.store_not_load && (priv_fault || write_fault);
      r.paddr = {ent.ptag, cmd.vaddr[PAGE_OFF_W-1:0]};
    end
    ptag = r.paddr[PADDR_W-1:PAGE_OFF_W];
    if (!r.miss) begin
      r.access_fault = (ptag[PTAG_W-1 -: DID_W] != '0);
    end
    return r;
  endfunction

  task automatic check_val(string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("** Error: test %s, %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      $display("Done: errors found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic check_resp();
    exp_s e;
    if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
      e = exp_q.pop_front();
      check_val("resp_v_o", 64'(e.v), 64'(resp_v_o));
      if (e.v) begin
        check_val("flags",
                  {e.r.miss, e.r.load_page_fault, e.r.store_page_fault, e.r.access_fault},
                  {resp_o.miss, resp_o.load_page_fault, resp_o.store_page_fault,
                   resp_o.access_fault});
        if (!e.r.miss) begin
          check_val("paddr", 64'(e.r.paddr), 64'(resp_o.paddr));
        end
      end
    end else begin
      check_val("idle resp_v_o", 64'(0), 64'(resp_v_o));
    end
  endtask

  // Advance one cycle, drop strobes and look at the response port
  task automatic tick();
    @(posedge clk_i);
    #1;
    cycle_cnt++;
    cmd_v_i  = 1'b0;
    fill_v_i = 1'b0;
    flush_i  = 1'b0;
    poison_i = 1'b0;
    check_resp();
  endtask

  task automatic drain();
    repeat (2) tick();
  endtask

  task automatic issue(vaddr_t va, logic store, logic present, tlb_entry_s ent, logic killed);
    exp_s e;
    cmd_v_i = 1'b1;
    cmd_i   = '{vaddr: va, store_not_load: store};
    e.due   = cycle_cnt + 2;
    e.v     = !killed;
    e.r     = model_resp(cmd_i, translation_en_i, priv_i, sum_i, present, ent);
    exp_q.push_back(e);
  endtask

  task automatic fill(vtag_t vtag, tlb_entry_s ent);
    fill_v_i     = 1'b1;
    fill_vtag_i  = vtag;
    fill_entry_i = ent;
    tick();
  endtask

  task automatic bare_mode_test();
    test_name = "bare_mode";
    translation_en_i = 1'b0;
    priv_i = PRIV_U;
    for (int i = 0; i < 16; i++) begin
      issue(rand_vaddr(), lcg_next() >> 31, 1'b1, '0, 1'b0);
      tick();
    end
    drain();
  endtask

  task automatic miss_fill_hit_test();
    vaddr_t     va;
    vaddr_t     va2;
    tlb_entry_s ent;
    test_name = "miss_fill_hit";
    translation_en_i = 1'b1;
    priv_i = PRIV_S;
    sum_i  = 1'b0;
    va = rand_vaddr();
    issue(va, 1'b0, 1'b0, '0, 1'b0);
    drain();
    check_val("miss_vaddr_o", 64'(va), 64'(miss_vaddr_o));
    ent = '{ptag: rand_ptag('0), u: 1'b0, w: 1'b1, d: 1'b1};
    fill(va[VADDR_W-1:PAGE_OFF_W], ent);
    // Back to back hit, store hit at another offset and a fresh miss
    issue(va, 1'b0, 1'b1, ent, 1'b0);
    tick();
    issue({va[VADDR_W-1:PAGE_OFF_W], 12'h5a8}, 1'b1, 1'b1, ent, 1'b0);
    tick();
    va2 = rand_vaddr();
    issue(va2, 1'b0, 1'b0, '0, 1'b0);
    drain();
    check_val("miss_vaddr_o", 64'(va2), 64'(miss_vaddr_o));
  endtask

  task automatic privilege_test(vaddr_t va_user, vaddr_t va_sup,
                                tlb_entry_s ent_user, tlb_entry_s ent_sup);
    test_name = "privilege";
    translation_en_i = 1'b1;
    for (int p = 0; p < 3; p++) begin
      for (int s = 0; s < 2; s++) begin
        priv_i = (p == 0) ? PRIV_U : (p == 1) ? PRIV_S : PRIV_M;
        sum_i  = s[0];
        issue(va_user, 1'b0, 1'b1, ent_user, 1'b0);
        tick();
        issue(va_sup, 1'b0, 1'b1, ent_sup, 1'b0);
        drain();
      end
    end
  endtask

  task automatic store_test();
    tlb_entry_s ent;
    vaddr_t     va;
    test_name = "store";
    priv_i = PRIV_M;
    for (int k = 0; k < 3; k++) begin
      va  = rand_vaddr();
      ent = '{ptag: rand_ptag('0), u: 1'b1, w: (k != 1), d: (k != 0)};
      fill(va[VADDR_W-1:PAGE_OFF_W], ent);
      issue(va, 1'b1, 1'b1, ent, 1'b0);
      tick();
      issue(va, 1'b0, 1'b1, ent, 1'b0);
      drain();
    end
  endtask

  task automatic poison_flush_test(vaddr_t va, tlb_entry_s ent);
    test_name = "poison_flush";
    priv_i = PRIV_U;
    issue(va, 1'b0, 1'b1, ent, 1'b0);
    tick();
    issue(va, 1'b0, 1'b1, ent, 1'b1);
    tick();
    issue(va, 1'b0, 1'b1, ent, 1'b0);
    poison_i = 1'b1;
    drain();
    flush_i = 1'b1;
    tick();
    issue(va, 1'b0, 1'b0, '0, 1'b0);
    drain();
    check_val("miss_vaddr_o", 64'(va), 64'(miss_vaddr_o));
  endtask

  task automatic domain_test();
    tlb_entry_s ent;
    vaddr_t     va;
    test_name = "domain";
    priv_i = PRIV_M;
    for (int k = 0; k < 2; k++) begin
      va  = rand_vaddr();
      ent = '{ptag: rand_ptag((k == 0) ? 2'b10 : 2'b00), u: 1'b0, w: 1'b1, d: 1'b1};
      fill(va[VADDR_W-1:PAGE_OFF_W], ent);
      issue(va, 1'b0, 1'b1, ent, 1'b0);
      drain();
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired before the tests finished");
  end

  initial begin
    vaddr_t     va_user;
    vaddr_t     va_sup;
    tlb_entry_s ent_user;
    tlb_entry_s ent_sup;
    clk_i = 1'b0;
    reset_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_i = '0;
    poison_i = 1'b0;
    fill_v_i = 1'b0;
    fill_vtag_i = '0;
    fill_entry_i = '0;
    flush_i = 1'b0;
    translation_en_i = 1'b0;
    priv_i = PRIV_M;
    sum_i = 1'b0;
    lcg_state = 32'd21;
    cycle_cnt = 0;
    test_name = "reset";
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_val("resp_v_o", 64'(0), 64'(resp_v_o));
    check_val("miss_vaddr_o", 64'(0), 64'(miss_vaddr_o));
    bare_mode_test();
    miss_fill_hit_test();
    va_user  = rand_vaddr();
    va_sup   = rand_vaddr();
    ent_user = '{ptag: rand_ptag('0), u: 1'b1, w: 1'b1, d: 1'b1};
    ent_sup  = '{ptag: rand_ptag('0), u: 1'b0, w: 1'b1, d: 1'b1};
    fill(va_user[VADDR_W-1:PAGE_OFF_W], ent_user);
    fill(va_sup[VADDR_W-1:PAGE_OFF_W], ent_sup);
    privilege_test(va_user, va_sup, ent_user, ent_sup);
    store_test();
    poison_flush_test(va_user, ent_user);
    domain_test();
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- dmmu.f
logic/mmu_pkg.sv
logic/dtlb.sv
logic/pte_check.sv
logic/resp_stage.sv
logic/dmmu_top.sv
sim/tb_dmmu.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module tb_dmmu -f dmmu.f -o sim_dmmu \
  && ./obj_dir/sim_dmmu \
  || exit 1
